// ==== src/xgmii_pkg.sv ====
// XGMII lane types and control characters, imported by the transmitter and its testbench
package xgmii_pkg;

    // byte lanes per XGMII word; the lane mux is written for four lanes
    localparam int lane_w = 4;

    // one data word, lane 0 in the low byte
    typedef logic [8*lane_w-1:0] xgmii_data_t;

    // one control bit per lane
    typedef logic [lane_w-1:0] xgmii_ctrl_t;

    // control characters that the transmitter emits
    typedef enum logic [7:0] {
        xgmii_idle  = 8'h07,
        xgmii_start = 8'hfb,
        xgmii_term  = 8'hfd,
        xgmii_error = 8'hfe
    } xgmii_char_t;

    // unused trailing bytes in the last word of a frame
    typedef logic [1:0] lane_empty_t;

endpackage

// ==== src/eth_frame_pkg.sv ====
// Ethernet framing constants and the transmit FSM state type, shared by RTL and testbench
package eth_frame_pkg;

    // preamble and start-of-frame delimiter bytes
    localparam logic [7:0] eth_pre = 8'h55;
    localparam logic [7:0] eth_sfd = 8'hd5;

    // CRC-32 generator, applied bit-reflected
    localparam logic [31:0] crc32_poly = 32'h04c11db7;
    localparam logic [31:0] crc32_init = 32'hffffffff;

    // frame check sequence length in bytes
    localparam int fcs_len = 4;

    // transmit controller states
    typedef enum logic [3:0] {
        state_idle,
        state_preamble,
        state_payload,
        state_pad,
        state_fcs_1,
        state_fcs_2,
        state_fcs_3,
        state_err,
        state_ifg
    } frame_state_t;

endpackage

// ==== src/fcs_if.sv ====
// link between the frame controller and the FCS generator, one modport per side
`timescale 1ns/1ns

interface fcs_if
    import xgmii_pkg::*;
();

    // held payload word and its trailing empty count
    xgmii_data_t word;
    lane_empty_t empty;
    logic        crc_init;
    logic        crc_update;

    // closing words, combinational from the generator registers
    xgmii_data_t fcs_word_0;
    xgmii_data_t fcs_word_1;
    xgmii_ctrl_t fcs_ctrl_1;
    logic        extra_cycle;
    logic [1:0]  idle_offset;

    modport ctrl (
        output word, empty, crc_init, crc_update,
        input  fcs_word_0, fcs_word_1, fcs_ctrl_1, extra_cycle, idle_offset
    );

    modport gen (
        input  word, empty, crc_init, crc_update,
        output fcs_word_0, fcs_word_1, fcs_ctrl_1, extra_cycle, idle_offset
    );

endinterface

// ==== src/eth_fcs_gen.sv ====
// CRC-32 generator for the transmitter, builds the FCS and terminate words of each frame
`timescale 1ns/1ns

module eth_fcs_gen
    import xgmii_pkg::*, eth_frame_pkg::*;
(
    input logic clk,
    input logic reset_crc,
    fcs_if.gen  fcs
);

    function automatic logic [31:0] bit_reverse(input logic [31:0] v);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = v[31-i];
        end
        return r;
    endfunction

    localparam logic [31:0] poly_r = bit_reverse(crc32_poly);

    // fold the low n bytes of data into crc, lsb first
    function automatic logic [31:0] crc_bytes(
        input logic [31:0] crc,
        input xgmii_data_t data,
        input int          n
    );
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8*lane_w; i++) begin
            if (i < 8*n) begin
                c = (c[0] ^ data[i]) ? ((c >> 1) ^ poly_r) : (c >> 1);
            end
        end
        return c;
    endfunction

    logic [31:0] crc_reg;
    logic [31:0] crc_step [lane_w];
    // partial-word results from the previous cycle, used in the terminate word
    logic [31:0] part_reg [lane_w-1];

    always_comb begin
        for (int n = 0; n < lane_w; n++) begin
            crc_step[n] = crc_bytes(crc_reg, fcs.word, n + 1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc || fcs.crc_init) begin
            crc_reg <= crc32_init;
        end else if (fcs.crc_update) begin
            crc_reg <= crc_step[lane_w-1];
        end
    end

    always_ff @(posedge clk) begin
        for (int n = 0; n < lane_w - 1; n++) begin
            part_reg[n] <= crc_step[n];
        end
    end

    // closing words by number of data bytes in the last word
    always_comb begin
        fcs.fcs_word_0  = fcs.word;
        fcs.fcs_word_1  = ~crc_reg;
        fcs.fcs_ctrl_1  = '0;
        fcs.extra_cycle = 1'b0;
        fcs.idle_offset = 2'd0;
        case (fcs.empty)
            2'd3: begin
                fcs.fcs_word_0  = {~crc_step[0][23:0], fcs.word[7:0]};
                fcs.fcs_word_1  = {{2{xgmii_idle}}, xgmii_term, ~part_reg[0][31:24]};
                fcs.fcs_ctrl_1  = 4'b1110;
                fcs.idle_offset = 2'd2;
            end
            2'd2: begin
                fcs.fcs_word_0  = {~crc_step[1][15:0], fcs.word[15:0]};
                fcs.fcs_word_1  = {xgmii_idle, xgmii_term, ~part_reg[1][31:16]};
                fcs.fcs_ctrl_1  = 4'b1100;
                fcs.idle_offset = 2'd1;
            end
            2'd1: begin
                fcs.fcs_word_0  = {~crc_step[2][7:0], fcs.word[23:0]};
                fcs.fcs_word_1  = {xgmii_term, ~part_reg[2][31:8]};
                fcs.fcs_ctrl_1  = 4'b1000;
                fcs.idle_offset = 2'd0;
            end
            default: begin
                // full last word, terminate goes out in a third word
                fcs.extra_cycle = 1'b1;
                fcs.idle_offset = 2'd3;
            end
        endcase
    end

endmodule

// ==== src/tx_frame_ctrl.sv ====
// transmit frame FSM: preamble, payload, padding, error ending and inter-frame gap
`timescale 1ns/1ns

module tx_frame_ctrl
    import xgmii_pkg::*, eth_frame_pkg::*;
#(
    parameter int MIN_FRAME_LEN = 64,
    parameter int IFG_BYTES     = 12
) (
    input  logic        clk,
    input  logic        reset_crc,
    input  xgmii_data_t s_tdata,
    input  xgmii_ctrl_t s_tkeep,
    input  logic        s_tlast,
    input  logic        s_tuser,
    input  logic        s_tvalid,
    output logic        s_tready,
    output xgmii_data_t xgmii_txd,
    output xgmii_ctrl_t xgmii_txc,
    fcs_if.ctrl         fcs
);

    localparam int min_len_w = $clog2(MIN_FRAME_LEN - fcs_len + 1);
    localparam int ifg_w     = $clog2(IFG_BYTES + 1);

    function automatic lane_empty_t keep2empty(input xgmii_ctrl_t keep);
        casez (keep)
            4'b1111: return 2'd0;
            4'b0111: return 2'd1;
            4'b?011: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    frame_state_t         state_reg, state_next;
    logic                 frame_reg, frame_next;
    logic                 frame_error_reg, frame_error_next;
    logic [min_len_w-1:0] min_count_reg, min_count_next;
    logic [ifg_w-1:0]     ifg_count_reg, ifg_count_next;
    logic                 tready_reg, tready_next;
    xgmii_data_t          word_reg, word_next;
    lane_empty_t          empty_reg, empty_next;
    xgmii_data_t          txd_reg, txd_next;
    xgmii_ctrl_t          txc_reg, txc_next;
    xgmii_data_t          in_word;
    lane_empty_t          in_empty;
    logic                 crc_init;
    logic                 crc_update;

    assign s_tready       = tready_reg;
    assign xgmii_txd      = txd_reg;
    assign xgmii_txc      = txc_reg;
    assign fcs.word       = word_reg;
    assign fcs.empty      = empty_reg;
    assign fcs.crc_init   = crc_init;
    assign fcs.crc_update = crc_update;

    // lane 0 always carries data; an underflow word reads as zeros
    always_comb begin
        for (int n = 0; n < lane_w; n++) begin
            in_word[8*n +: 8] = (n == 0 || s_tkeep[n]) ? s_tdata[8*n +: 8] : 8'h00;
        end
        if (!s_tvalid) begin
            in_word = '0;
        end
        in_empty = s_tvalid ? keep2empty(s_tkeep) : lane_empty_t'(0);
    end

    always_comb begin
        state_next       = state_reg;
        frame_next       = frame_reg;
        frame_error_next = frame_error_reg;
        ifg_count_next   = ifg_count_reg;
        tready_next      = 1'b0;
        word_next        = word_reg;
        empty_next       = empty_reg;
        txd_next         = {lane_w{xgmii_idle}};
        txc_next         = '1;
        crc_init         = 1'b0;
        crc_update       = 1'b0;

        if (s_tvalid && tready_reg) begin
            frame_next = !s_tlast;
        end

        // minimum-length budget, four bytes per cycle
        if (min_count_reg > min_len_w'(lane_w)) begin
            min_count_next = min_count_reg - min_len_w'(lane_w);
        end else begin
            min_count_next = '0;
        end

        case (state_reg)
            state_idle: begin
                frame_error_next = 1'b0;
                min_count_next   = min_len_w'(MIN_FRAME_LEN - fcs_len);
                crc_init         = 1'b1;
                if (s_tvalid) begin
                    txd_next    = {{3{eth_pre}}, xgmii_start};
                    txc_next    = 4'b0001;
                    tready_next = 1'b1;
                    state_next  = state_preamble;
                end
            end
            state_preamble: begin
                crc_init    = 1'b1;
                word_next   = in_word;
                empty_next  = in_empty;
                txd_next    = {eth_sfd, {3{eth_pre}}};
                txc_next    = '0;
                tready_next = 1'b1;
                state_next  = state_payload;
            end
            state_payload: begin
                crc_update  = 1'b1;
                tready_next = 1'b1;
                txd_next    = word_reg;
                txc_next    = '0;
                word_next   = in_word;
                empty_next  = in_empty;

                // short frame, widen the last word up to the budget
                if (min_count_reg != '0) begin
                    if (min_count_reg > min_len_w'(lane_w)) begin
                        empty_next = '0;
                    end else if (in_empty > lane_empty_t'(lane_w - min_count_reg)) begin
                        empty_next = lane_empty_t'(lane_w - min_count_reg);
                    end
                end

                if (!s_tvalid || s_tlast) begin
                    tready_next      = frame_next;
                    frame_error_next = !s_tvalid || s_tuser;
                    if (min_count_reg > min_len_w'(lane_w)) begin
                        state_next = state_pad;
                    end else begin
                        state_next = state_fcs_1;
                    end
                end
            end
            state_pad: begin
                crc_update  = 1'b1;
                tready_next = frame_next;
                txd_next    = word_reg;
                txc_next    = '0;
                word_next   = '0;
                empty_next  = '0;
                if (min_count_reg <= min_len_w'(lane_w)) begin
                    empty_next = lane_empty_t'(lane_w - min_count_reg);
                    state_next = state_fcs_1;
                end
            end
            state_fcs_1: begin
                crc_update     = 1'b1;
                tready_next    = frame_next;
                txd_next       = fcs.fcs_word_0;
                txc_next       = '0;
                ifg_count_next = ifg_w'(IFG_BYTES) - ifg_w'(fcs.idle_offset);
                state_next     = frame_error_reg ? state_err : state_fcs_2;
            end
            state_fcs_2: begin
                tready_next = frame_next;
                txd_next    = fcs.fcs_word_1;
                txc_next    = fcs.fcs_ctrl_1;
                state_next  = fcs.extra_cycle ? state_fcs_3 : state_ifg;
            end
            state_fcs_3: begin
                tready_next = frame_next;
                txd_next    = {{3{xgmii_idle}}, xgmii_term};
                txc_next    = '1;
                state_next  = state_ifg;
            end
            state_err: begin
                tready_next    = frame_next;
                txd_next       = {xgmii_term, {3{xgmii_error}}};
                txc_next       = '1;
                ifg_count_next = ifg_w'(IFG_BYTES);
                state_next     = state_ifg;
            end
            state_ifg: begin
                // keep draining a bad frame until its last word
                tready_next = frame_next;
                if (ifg_count_reg > ifg_w'(lane_w)) begin
                    ifg_count_next = ifg_count_reg - ifg_w'(lane_w);
                end else begin
                    ifg_count_next = '0;
                end
                if (ifg_count_next == '0 && !frame_next) begin
                    state_next = state_idle;
                end
            end
            default: begin
                state_next = state_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state_reg       <= state_idle;
            frame_reg       <= 1'b0;
            frame_error_reg <= 1'b0;
            ifg_count_reg   <= '0;
            tready_reg      <= 1'b0;
            txd_reg         <= {lane_w{xgmii_idle}};
            txc_reg         <= '1;
        end else begin
            state_reg       <= state_next;
            frame_reg       <= frame_next;
            frame_error_reg <= frame_error_next;
            ifg_count_reg   <= ifg_count_next;
            tready_reg      <= tready_next;
            txd_reg         <= txd_next;
            txc_reg         <= txc_next;
        end
    end

    always_ff @(posedge clk) begin
        min_count_reg <= min_count_next;
        word_reg      <= word_next;
        empty_reg     <= empty_next;
    end

endmodule

// ==== src/xgmii_tx.sv ====
// 32-bit Ethernet transmitter top level, byte-keyed word stream in and XGMII out
`timescale 1ns/1ns

module xgmii_tx
    import xgmii_pkg::*;
#(
    parameter int MIN_FRAME_LEN = 64,
    parameter int IFG_BYTES     = 12
) (
    input  logic        clk,
    input  logic        reset_crc,
    input  xgmii_data_t s_tdata,
    input  xgmii_ctrl_t s_tkeep,
    input  logic        s_tlast,
    input  logic        s_tuser,
    input  logic        s_tvalid,
    output logic        s_tready,
    output xgmii_data_t xgmii_txd,
    output xgmii_ctrl_t xgmii_txc
);

    fcs_if fcs ();

    // sequencing and output registers
    tx_frame_ctrl #(
        .MIN_FRAME_LEN (MIN_FRAME_LEN),
        .IFG_BYTES     (IFG_BYTES)
    ) ctrl0 (
        .clk       (clk),
        .reset_crc (reset_crc),
        .s_tdata   (s_tdata),
        .s_tkeep   (s_tkeep),
        .s_tlast   (s_tlast),
        .s_tuser   (s_tuser),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .xgmii_txd (xgmii_txd),
        .xgmii_txc (xgmii_txc),
        .fcs       (fcs.ctrl)
    );

    // CRC and closing word assembly
    eth_fcs_gen gen0 (
        .clk       (clk),
        .reset_crc (reset_crc),
        .fcs       (fcs.gen)
    );

endmodule

// ==== tb/xgmii_tx_checker.sv ====
// XGMII protocol assertions, bound into the transmitter top level by the testbench
`timescale 1ns/1ns

module xgmii_tx_checker
    import xgmii_pkg::*;
(
    input logic        clk,
    input logic        reset_crc,
    input logic        s_tvalid,
    input logic        s_tready,
    input xgmii_data_t xgmii_txd,
    input xgmii_ctrl_t xgmii_txc
);

    int   fail_count = 0;
    logic idle_out;

    assign idle_out = (xgmii_txc == '1) && (xgmii_txd == {lane_w{xgmii_idle}});

    function automatic logic ctrl_lanes_defined(input xgmii_data_t d, input xgmii_ctrl_t c);
        logic       ok;
        logic [7:0] b;
        ok = 1'b1;
        for (int n = 0; n < lane_w; n++) begin
            b = d[8*n +: 8];
            if (c[n] && !(b inside {xgmii_idle, xgmii_start, xgmii_term, xgmii_error})) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic logic start_in_upper_lane(input xgmii_data_t d, input xgmii_ctrl_t c);
        logic found;
        found = 1'b0;
        for (int n = 1; n < lane_w; n++) begin
            if (c[n] && d[8*n +: 8] == xgmii_start) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    reset_outputs_idle: assert property (@(posedge clk)
        reset_crc |=> idle_out && !s_tready)
        else begin $error("output not idle during reset"); fail_count = fail_count + 1; end

    // first cycle out of reset, nothing offered yet
    after_reset_idle: assert property (@(posedge clk)
        (reset_crc ##1 (!reset_crc && !s_tvalid)) |=> idle_out && !s_tready)
        else begin $error("output not idle after reset"); fail_count = fail_count + 1; end

    start_lane_zero: assert property (@(posedge clk) disable iff (reset_crc)
        !start_in_upper_lane(xgmii_txd, xgmii_txc) &&
        ((xgmii_txc[0] && xgmii_txd[7:0] == xgmii_start) -> xgmii_txc == 4'b0001))
        else begin $error("start character misplaced"); fail_count = fail_count + 1; end

    ctrl_char_known: assert property (@(posedge clk) disable iff (reset_crc)
        ctrl_lanes_defined(xgmii_txd, xgmii_txc))
        else begin $error("unknown control character"); fail_count = fail_count + 1; end

endmodule

// ==== tb/xgmii_tx_tb.sv ====
// testbench for the XGMII transmitter: random frames in, XGMII bytes checked against a model
`timescale 1ns/1ns

module xgmii_tx_tb
    import xgmii_pkg::*, eth_frame_pkg::*;
#(
    parameter int MIN_FRAME_LEN = 64,
    parameter int IFG_BYTES     = 12
) ();

    typedef logic [7:0] byte_q_t[$];
    // one XGMII lane as {control bit, byte}
    typedef logic [8:0] lane_q_t[$];

    localparam int kind_good      = 0;
    localparam int kind_user      = 1;
    localparam int kind_underflow = 2;
    localparam int drop_word      = 2;
    localparam int frame_count    = 24;
    localparam int max_words      = 56;
    localparam int gap_words      = IFG_BYTES / 4 + 4;
    localparam int watchdog_ns    = frame_count * (max_words + gap_words + 4) * 4 * 2;

    logic        clk;
    logic        reset_crc;
    xgmii_data_t s_tdata;
    xgmii_ctrl_t s_tkeep;
    logic        s_tlast;
    logic        s_tuser;
    logic        s_tvalid;
    logic        s_tready;
    xgmii_data_t xgmii_txd;
    xgmii_ctrl_t xgmii_txc;

    logic [15:0] lfsr_q = 16'd39600;
    logic [8:0]  rx_bytes[$];
    int          rx_len[$];
    logic [8:0]  exp_bytes[$];
    int          exp_len[$];
    bit          exp_err[$];
    int          frames_checked = 0;

    xgmii_tx #(
        .MIN_FRAME_LEN (MIN_FRAME_LEN),
        .IFG_BYTES     (IFG_BYTES)
    ) dut0 (
        .clk       (clk),
        .reset_crc (reset_crc),
        .s_tdata   (s_tdata),
        .s_tkeep   (s_tkeep),
        .s_tlast   (s_tlast),
        .s_tuser   (s_tuser),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .xgmii_txd (xgmii_txd),
        .xgmii_txc (xgmii_txc)
    );

    bind xgmii_tx xgmii_tx_checker chk0 (
        .clk       (clk),
        .reset_crc (reset_crc),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .xgmii_txd (xgmii_txd),
        .xgmii_txc (xgmii_txc)
    );

    always #2 clk = ~clk;

    // taps 16, 14, 13, 11
    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        logic        fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            v      = (v << 1) | lfsr_q[15];
            lfsr_q = {lfsr_q[14:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] crc32_ref(input byte_q_t data);
        logic [31:0] c;
        c = 32'hffffffff;
        foreach (data[i]) begin
            c = c ^ {24'h0, data[i]};
            for (int b = 0; b < 8; b++) begin
                // reflected form of 04c11db7
                c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    function automatic lane_q_t build_expected(input byte_q_t payload, input int kind);
        lane_q_t     q;
        byte_q_t     body;
        logic [31:0] fcs;
        int          n;
        q = {};
        q.push_back({1'b1, xgmii_start});
        repeat (6) q.push_back({1'b0, eth_pre});
        q.push_back({1'b0, eth_sfd});
        if (kind == kind_good) begin
            body = payload;
            while (body.size() < MIN_FRAME_LEN - fcs_len) begin
                body.push_back(8'h00);
            end
            fcs = crc32_ref(body);
            foreach (body[i]) begin
                q.push_back({1'b0, body[i]});
            end
            for (int i = 0; i < fcs_len; i++) begin
                q.push_back({1'b0, fcs[8*i +: 8]});
            end
            q.push_back({1'b1, xgmii_term});
        end else begin
            // only the bytes sent before the fault are known
            n = (kind == kind_underflow) ? 4 * drop_word : payload.size();
            for (int i = 0; i < n; i++) begin
                q.push_back({1'b0, payload[i]});
            end
            repeat (3) q.push_back({1'b1, xgmii_error});
            q.push_back({1'b1, xgmii_term});
        end
        return q;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            report_failure($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, want));
        end
    endtask

    task automatic idle_cycle();
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        s_tuser  = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic put_word(input xgmii_data_t data, input xgmii_ctrl_t keep,
                            input logic last, input logic user);
        bit taken;
        s_tdata  = data;
        s_tkeep  = keep;
        s_tlast  = last;
        s_tuser  = user;
        s_tvalid = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = s_tready;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_frame(input byte_q_t payload, input int kind);
        int          nwords;
        xgmii_data_t d;
        xgmii_ctrl_t k;
        nwords = (payload.size() + 3) / 4;
        for (int w = 0; w < nwords; w++) begin
            if (kind == kind_underflow && w == drop_word) begin
                idle_cycle();
            end
            for (int b = 0; b < lane_w; b++) begin
                k[b] = (4*w + b) < payload.size();
                // lanes past the end carry junk that must be masked
                d[8*b +: 8] = k[b] ? payload[4*w + b] : 8'(take_bits(8));
            end
            put_word(d, k, w == nwords - 1, kind == kind_user && w == nwords - 1);
        end
    endtask

    initial begin : stimulus
        byte_q_t payload;
        lane_q_t want;
        int      kind;
        int      len;
        int      idles;
        clk       = 1'b0;
        reset_crc = 1'b1;
        s_tdata   = '0;
        s_tkeep   = '0;
        s_tlast   = 1'b0;
        s_tuser   = 1'b0;
        s_tvalid  = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset_crc = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value("s_tready", s_tready, 0);
            check_value("xgmii_txc", xgmii_txc, 4'hf);
            check_value("xgmii_txd", xgmii_txd, {lane_w{xgmii_idle}});
        end
        @(posedge clk);
        #1;
        for (int f = 0; f < frame_count; f++) begin
            case (f % 6)
                2:       kind = kind_user;
                4:       kind = kind_underflow;
                default: kind = kind_good;
            endcase
            if (f % 6 == 1 || f % 6 == 5) begin
                len = 17 + take_bits(6) % (MIN_FRAME_LEN - 21);
            end else begin
                len = 64 + 4 * (take_bits(6) % 34) + f % 4;
            end
            payload = {};
            repeat (len) payload.push_back(8'(take_bits(8)));
            want = build_expected(payload, kind);
            foreach (want[i]) begin
                exp_bytes.push_back(want[i]);
            end
            exp_len.push_back(want.size());
            exp_err.push_back(kind != kind_good);
            send_frame(payload, kind);
            // zero here gives back-to-back frames
            idles = take_bits(2);
            repeat (idles) idle_cycle();
        end
        idle_cycle();
        while (frames_checked < frame_count) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (dut0.chk0.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // split XGMII words into lanes, cut frames at start and terminate
    initial begin : monitor
        bit         in_frame;
        bit         seen_term;
        int         gap;
        int         count;
        logic [7:0] b;
        logic       c;
        in_frame  = 1'b0;
        seen_term = 1'b0;
        gap       = 0;
        count     = 0;
        forever begin
            @(negedge clk);
            if (!reset_crc) begin
                for (int n = 0; n < lane_w; n++) begin
                    b = xgmii_txd[8*n +: 8];
                    c = xgmii_txc[n];
                    if (in_frame) begin
                        rx_bytes.push_back({c, b});
                        count++;
                        if (c && b == xgmii_term) begin
                            in_frame  = 1'b0;
                            seen_term = 1'b1;
                            gap       = 0;
                            rx_len.push_back(count);
                        end
                    end else if (c && b == xgmii_start) begin
                        if (seen_term && gap < IFG_BYTES) begin
                            report_failure($sformatf("gap of %0d idles is shorter than %0d",
                                gap, IFG_BYTES));
                        end
                        in_frame = 1'b1;
                        count    = 1;
                        rx_bytes.push_back({c, b});
                    end else if (c && b == xgmii_idle) begin
                        gap++;
                    end else begin
                        report_failure($sformatf("byte %0h on lane %0d outside of a frame", b, n));
                    end
                end
            end
        end
    end

    initial begin : compare
        logic [8:0] got[$];
        logic [8:0] want[$];
        int         n_got;
        int         n_want;
        bit         is_err;
        for (int f = 0; f < frame_count; f++) begin
            while (rx_len.size() == 0) begin
                @(negedge clk);
            end
            n_got  = rx_len.pop_front();
            n_want = exp_len.pop_front();
            is_err = exp_err.pop_front();
            got    = {};
            want   = {};
            repeat (n_got) got.push_back(rx_bytes.pop_front());
            repeat (n_want) want.push_back(exp_bytes.pop_front());
            if (!is_err) begin
                check_value("frame length", n_got, n_want);
            end else if (n_got < n_want) begin
                report_failure($sformatf("error frame %0d is only %0d bytes long", f, n_got));
            end
            for (int i = 0; i < n_want; i++) begin
                // error frames: known head, then the four closing lanes
                if (!is_err || i < n_want - 4) begin
                    check_value($sformatf("xgmii_txd frame %0d byte %0d", f, i), got[i], want[i]);
                end else begin
                    check_value($sformatf("xgmii_txd frame %0d tail %0d", f, i - n_want + 4),
                        got[n_got - n_want + i], want[i]);
                end
            end
            frames_checked++;
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("Timeout: frames still pending after %0d ns", watchdog_ns);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== xgmii_tx.f ====
src/xgmii_pkg.sv
src/eth_frame_pkg.sv
src/fcs_if.sv
src/eth_fcs_gen.sv
src/tx_frame_ctrl.sv
src/xgmii_tx.sv
tb/xgmii_tx_checker.sv
tb/xgmii_tx_tb.sv

// ==== Bender.yml ====
package:
  name: xgmii_tx

sources:
  - src/xgmii_pkg.sv
  - src/eth_frame_pkg.sv
  - src/fcs_if.sv
  - src/eth_fcs_gen.sv
  - src/tx_frame_ctrl.sv
  - src/xgmii_tx.sv
  - target: test
    files:
      - tb/xgmii_tx_checker.sv
      - tb/xgmii_tx_tb.sv
